//--- common/rx_frontend_pkg.sv
`default_nettype none

package rx_frontend_pkg;

   localparam int ADC_W    = 16;
   localparam int SAMPLE_W = 24;
   localparam int CORR_W   = 18;
   localparam int ADDR_W   = 8;
   localparam int DATA_W   = 32;

   typedef logic        [ADC_W-1:0]    adc_sample_t;
   typedef logic signed [SAMPLE_W-1:0] rx_sample_t;
   typedef logic signed [CORR_W-1:0]   corr_t;    // Q1.17
   typedef logic        [ADDR_W-1:0]   set_addr_t;
   typedef logic        [DATA_W-1:0]   set_data_t;

   localparam set_addr_t SR_BASE  = 8'd0;
   localparam set_addr_t SR_SWAP  = SR_BASE + 8'd0;
   localparam set_addr_t SR_MAG   = SR_BASE + 8'd1;
   localparam set_addr_t SR_PHASE = SR_BASE + 8'd2;
   localparam set_addr_t SR_DC_I  = SR_BASE + 8'd3;
   localparam set_addr_t SR_DC_Q  = SR_BASE + 8'd4;

   localparam int DC_FIXED_BIT = 31;                  // set selects a fixed offset
   localparam int WIDEN_SHIFT  = SAMPLE_W - ADC_W;    // adc word sits in the top bits

   localparam int DC_SHIFT   = 14;                    // tracking gain is 2^-14 per sample
   localparam int DC_ACC_W   = SAMPLE_W + DC_SHIFT;
   localparam int CORR_SHIFT = 17;
   localparam int PROD_W     = SAMPLE_W + CORR_W;
   localparam int CLIP_W     = SAMPLE_W + 2;          // wide enough for any sum before clipping

   localparam rx_sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
   localparam rx_sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

   // saturate a wide signed value to the 24-bit sample range
   function automatic rx_sample_t clip_sample(input logic signed [CLIP_W-1:0] value);
      rx_sample_t result;
      if (value > SAMPLE_MAX)
         result = SAMPLE_MAX;
      else if (value < SAMPLE_MIN)
         result = SAMPLE_MIN;
      else
         result = value[SAMPLE_W-1:0];
      return result;
   endfunction

endpackage

`default_nettype wire

//--- rtl/iq_balance.sv
`timescale 1ns/1ps
`default_nettype none

module iq_balance
   import rx_frontend_pkg::*;
(
   input  wire             clk,
   input  wire             reset_i,
   input  wire rx_sample_t i_i,
   input  wire rx_sample_t q_i,
   input  wire corr_t      mag_corr_i,
   input  wire corr_t      phase_corr_i,
   output rx_sample_t      i_o,
   output rx_sample_t      q_o
);

   logic signed [PROD_W-1:0] prod_mag_q;
   logic signed [PROD_W-1:0] prod_phase_q;
   rx_sample_t               i_d_q;
   rx_sample_t               q_d_q;
   logic signed [PROD_W-1:0] shift_mag;
   logic signed [PROD_W-1:0] shift_phase;
   logic signed [CLIP_W-1:0] sum_i;
   logic signed [CLIP_W-1:0] sum_q;

   // both products come from the I channel
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         prod_mag_q   <= '0;
         prod_phase_q <= '0;
         i_d_q        <= '0;
         q_d_q        <= '0;
      end
      else
      begin
         prod_mag_q   <= i_i * mag_corr_i;
         prod_phase_q <= i_i * phase_corr_i;
         i_d_q        <= i_i;
         q_d_q        <= q_i;
      end
   end

   assign shift_mag   = prod_mag_q >>> CORR_SHIFT;  // floor, rounds toward minus infinity
   assign shift_phase = prod_phase_q >>> CORR_SHIFT;

   // shifted product fits in 25 bits, so the low CLIP_W bits are exact
   assign sum_i = i_d_q + signed'(shift_mag[CLIP_W-1:0]);
   assign sum_q = q_d_q + signed'(shift_phase[CLIP_W-1:0]);

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         i_o <= '0;
         q_o <= '0;
      end
      else
      begin
         i_o <= clip_sample(sum_i);
         q_o <= clip_sample(sum_q);
      end
   end

endmodule

`default_nettype wire

//--- rtl/rx_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frontend
   import rx_frontend_pkg::*;
(
   input  wire              clk,
   input  wire              reset_i,
   input  wire              set_stb_i,
   input  wire set_addr_t   set_addr_i,
   input  wire set_data_t   set_data_i,
   input  wire adc_sample_t adc_a_i,
   input  wire adc_sample_t adc_b_i,
   input  wire              run_i,
   output rx_sample_t       i_out_o,
   output rx_sample_t       q_out_o
);

   logic       swap;
   corr_t      mag_corr;
   corr_t      phase_corr;
   logic       dc_load_i;
   logic       dc_load_q;
   rx_sample_t dc_value_i;
   rx_sample_t dc_value_q;
   logic       dc_fixed_i;
   logic       dc_fixed_q;
   rx_sample_t adc_i_q;
   rx_sample_t adc_q_q;
   rx_sample_t i_ofs;
   rx_sample_t q_ofs;

   rx_settings settings (
      .clk          (clk),
      .reset_i      (reset_i),
      .set_stb_i    (set_stb_i),
      .set_addr_i   (set_addr_i),
      .set_data_i   (set_data_i),
      .swap_o       (swap),
      .mag_corr_o   (mag_corr),
      .phase_corr_o (phase_corr),
      .dc_load_i_o  (dc_load_i),
      .dc_load_q_o  (dc_load_q),
      .dc_value_i_o (dc_value_i),
      .dc_value_q_o (dc_value_q),
      .dc_fixed_i_o (dc_fixed_i),
      .dc_fixed_q_o (dc_fixed_q)
   );

   // swap and widen in one stage, the adc word becomes the top 16 bits
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         adc_i_q <= '0;
         adc_q_q <= '0;
      end
      else if (swap)
      begin
         adc_i_q <= {adc_b_i, {WIDEN_SHIFT{1'b0}}};
         adc_q_q <= {adc_a_i, {WIDEN_SHIFT{1'b0}}};
      end
      else
      begin
         adc_i_q <= {adc_a_i, {WIDEN_SHIFT{1'b0}}};
         adc_q_q <= {adc_b_i, {WIDEN_SHIFT{1'b0}}};
      end
   end

   rx_dcoffset dc_i (
      .clk          (clk),
      .reset_i      (reset_i),
      .run_i        (run_i),
      .load_i       (dc_load_i),
      .load_value_i (dc_value_i),
      .fixed_i      (dc_fixed_i),
      .sample_i     (adc_i_q),
      .sample_o     (i_ofs)
   );

   rx_dcoffset dc_q (
      .clk          (clk),
      .reset_i      (reset_i),
      .run_i        (run_i),
      .load_i       (dc_load_q),
      .load_value_i (dc_value_q),
      .fixed_i      (dc_fixed_q),
      .sample_i     (adc_q_q),
      .sample_o     (q_ofs)
   );

   iq_balance balance (
      .clk          (clk),
      .reset_i      (reset_i),
      .i_i          (i_ofs),
      .q_i          (q_ofs),
      .mag_corr_i   (mag_corr),
      .phase_corr_i (phase_corr),
      .i_o          (i_out_o),
      .q_o          (q_out_o)
   );

endmodule

`default_nettype wire

//--- rtl/rx_settings.sv
`timescale 1ns/1ps
`default_nettype none

module rx_settings
   import rx_frontend_pkg::*;
(
   input  wire            clk,
   input  wire            reset_i,
   input  wire            set_stb_i,
   input  wire set_addr_t set_addr_i,
   input  wire set_data_t set_data_i,
   output logic           swap_o,
   output corr_t          mag_corr_o,
   output corr_t          phase_corr_o,
   output logic           dc_load_i_o,
   output logic           dc_load_q_o,
   output rx_sample_t     dc_value_i_o,
   output rx_sample_t     dc_value_q_o,
   output logic           dc_fixed_i_o,
   output logic           dc_fixed_q_o
);

   logic hit_dc_i;
   logic hit_dc_q;

   assign hit_dc_i = set_stb_i && (set_addr_i == SR_DC_I);
   assign hit_dc_q = set_stb_i && (set_addr_i == SR_DC_Q);

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         swap_o       <= 1'b0;
         mag_corr_o   <= '0;
         phase_corr_o <= '0;
         dc_value_i_o <= '0;
         dc_value_q_o <= '0;
         dc_fixed_i_o <= 1'b0;
         dc_fixed_q_o <= 1'b0;
      end
      else if (set_stb_i)
      begin
         case (set_addr_i)
            SR_SWAP:  swap_o       <= set_data_i[0];
            SR_MAG:   mag_corr_o   <= set_data_i[CORR_W-1:0];
            SR_PHASE: phase_corr_o <= set_data_i[CORR_W-1:0];
            SR_DC_I:
            begin
               dc_value_i_o <= set_data_i[SAMPLE_W-1:0];
               dc_fixed_i_o <= set_data_i[DC_FIXED_BIT];
            end
            SR_DC_Q:
            begin
               dc_value_q_o <= set_data_i[SAMPLE_W-1:0];
               dc_fixed_q_o <= set_data_i[DC_FIXED_BIT];
            end
            default: ;  // other addresses belong to other blocks
         endcase
      end
   end

   // load pulses land together with the new offset value
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         dc_load_i_o <= 1'b0;
         dc_load_q_o <= 1'b0;
      end
      else
      begin
         dc_load_i_o <= hit_dc_i;
         dc_load_q_o <= hit_dc_q;
      end
   end

   // a DC word is never written on two consecutive bus cycles
   a_load_i_pulse: assert property (@(posedge clk) disable iff (reset_i)
      dc_load_i_o |=> !dc_load_i_o);
   a_load_q_pulse: assert property (@(posedge clk) disable iff (reset_i)
      dc_load_q_o |=> !dc_load_q_o);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs tb_rx_frontend with Verilator, then searches the log for the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_rx_frontend

rm -rf obj_dir "$LOG"

{ verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f rx_frontend.f \
   && "./obj_dir/V$TOP"; } > "$LOG" 2>&1 \
   || echo "Verification failed" >> "$LOG"

cat "$LOG"

grep -q "Verification failed" "$LOG" && { echo "simulation FAILED, see $LOG"; exit 1; }
echo "simulation PASSED"
exit 0

//--- rx_dcoffset/rx_dcoffset.sv
`timescale 1ns/1ps
`default_nettype none

module rx_dcoffset
   import rx_frontend_pkg::*;
(
   input  wire             clk,
   input  wire             reset_i,
   input  wire             run_i,
   input  wire             load_i,
   input  wire rx_sample_t load_value_i,
   input  wire             fixed_i,
   input  wire rx_sample_t sample_i,
   output rx_sample_t      sample_o
);

   logic signed [DC_ACC_W-1:0] acc_q;
   logic signed [DC_ACC_W-1:0] acc_load;
   rx_sample_t                 offset;
   logic signed [CLIP_W-1:0]   diff;
   logic                       track;

   // integer part of the integrator is the offset in use
   assign offset   = acc_q[DC_ACC_W-1:DC_SHIFT];
   assign acc_load = {load_value_i, {DC_SHIFT{1'b0}}};
   assign diff     = sample_i - offset;
   assign track    = run_i && !fixed_i;

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         sample_o <= '0;
      end
      else
      begin
         sample_o <= clip_sample(diff);
      end
   end

   // feeding the output back drives its mean toward zero
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         acc_q <= '0;
      end
      else if (load_i)
      begin
         acc_q <= acc_load;
      end
      else if (track)
      begin
         acc_q <= acc_q + sample_o;
      end
   end

   // the offset only moves when a load arrives or while tracking is active
   a_acc_hold: assert property (@(posedge clk) disable iff (reset_i)
      (!load_i && (fixed_i || !run_i)) |=> $stable(acc_q));

endmodule

`default_nettype wire

//--- rx_frontend.f
common/rx_frontend_pkg.sv
rtl/rx_settings.sv
rx_dcoffset/rx_dcoffset.sv
rtl/iq_balance.sv
rtl/rx_frontend.sv
testbench/rx_frontend_checker.sv
testbench/tb_rx_frontend.sv

//--- testbench/rx_frontend_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frontend_checker
   import rx_frontend_pkg::*;
(
   input  wire              clk,
   input  wire              reset_i,
   input  wire              set_stb_i,
   input  wire set_addr_t   set_addr_i,
   input  wire set_data_t   set_data_i,
   input  wire adc_sample_t adc_a_i,
   input  wire adc_sample_t adc_b_i,
   input  wire              compare_i,
   input  wire rx_sample_t  i_out_i,
   input  wire rx_sample_t  q_out_i,
   output int               error_count_o,
   output int               check_count_o
);

   localparam int FRONTEND_LATENCY = 4;

   logic       swap_m;
   corr_t      mag_m;
   corr_t      phase_m;
   rx_sample_t dc_i_m;
   rx_sample_t dc_q_m;
   rx_sample_t next_i;
   rx_sample_t next_q;
   rx_sample_t exp_i [FRONTEND_LATENCY];
   rx_sample_t exp_q [FRONTEND_LATENCY];
   logic       exp_cmp [FRONTEND_LATENCY];

   function automatic rx_sample_t saturate24(input longint value);
      rx_sample_t result;
      if (value > 64'sd8388607)
         result = 24'h7fffff;
      else if (value < -64'sd8388608)
         result = 24'h800000;
      else
         result = value[23:0];
      return result;
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         swap_m  <= 1'b0;
         mag_m   <= '0;
         phase_m <= '0;
         dc_i_m  <= '0;
         dc_q_m  <= '0;
      end
      else if (set_stb_i)
      begin
         case (set_addr_i)
            SR_SWAP:  swap_m  <= set_data_i[0];
            SR_MAG:   mag_m   <= set_data_i[CORR_W-1:0];
            SR_PHASE: phase_m <= set_data_i[CORR_W-1:0];
            SR_DC_I:  dc_i_m  <= set_data_i[SAMPLE_W-1:0];
            SR_DC_Q:  dc_q_m  <= set_data_i[SAMPLE_W-1:0];
            default: ;
         endcase
      end
   end

   // exact rows keep the integrator at the loaded value, so the offset is the mirrored word
   always_comb
   begin : model
      longint     a_w;
      longint     b_w;
      rx_sample_t i_dc;
      rx_sample_t q_dc;
      a_w    = longint'(signed'(adc_a_i)) <<< 8;
      b_w    = longint'(signed'(adc_b_i)) <<< 8;
      i_dc   = saturate24((swap_m ? b_w : a_w) - longint'(dc_i_m));
      q_dc   = saturate24((swap_m ? a_w : b_w) - longint'(dc_q_m));
      next_i = saturate24(longint'(i_dc) + ((longint'(i_dc) * longint'(mag_m)) >>> CORR_SHIFT));
      next_q = saturate24(longint'(q_dc) + ((longint'(i_dc) * longint'(phase_m)) >>> CORR_SHIFT));
   end

   always @(posedge clk)
   begin
      if (reset_i)
      begin
         error_count_o = 0;
         check_count_o = 0;
         for (int n = 0; n < FRONTEND_LATENCY; n++)
         begin
            exp_i[n]   <= '0;
            exp_q[n]   <= '0;
            exp_cmp[n] <= 1'b1;  // outputs must read zero right after reset
         end
      end
      else
      begin
         if (exp_cmp[FRONTEND_LATENCY-1])
         begin
            check_count_o = check_count_o + 1;
            if (i_out_i !== exp_i[FRONTEND_LATENCY-1])
            begin
               $display("mismatch i_out_o at %0t: expected 0x%h, got 0x%h",
                        $time, exp_i[FRONTEND_LATENCY-1], i_out_i);
               error_count_o = error_count_o + 1;
            end
            if (q_out_i !== exp_q[FRONTEND_LATENCY-1])
            begin
               $display("mismatch q_out_o at %0t: expected 0x%h, got 0x%h",
                        $time, exp_q[FRONTEND_LATENCY-1], q_out_i);
               error_count_o = error_count_o + 1;
            end
         end
         exp_i[0]   <= next_i;
         exp_q[0]   <= next_q;
         exp_cmp[0] <= compare_i;
         for (int n = 1; n < FRONTEND_LATENCY; n++)
         begin
            exp_i[n]   <= exp_i[n-1];
            exp_q[n]   <= exp_q[n-1];
            exp_cmp[n] <= exp_cmp[n-1];
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_rx_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rx_frontend
   import rx_frontend_pkg::*;
();

   localparam int NUM_ROWS    = 8;
   localparam int HALF_PERIOD = 20;
   localparam int PIPE_DEPTH  = 4;
   localparam int TRACK_LIMIT = 1024;

   typedef struct packed {
      logic        swap;
      corr_t       mag;
      corr_t       phase;
      set_data_t   dc_i;
      set_data_t   dc_q;
      logic        run;
      logic        rnd;      // xorshift samples instead of the constants
      adc_sample_t const_a;
      adc_sample_t const_b;
      logic [31:0] count;    // sample count, or the cycle limit of a tracking row
      logic        exact;
   } row_t;

   logic        clk;
   logic        reset_i;
   logic        set_stb_i;
   set_addr_t   set_addr_i;
   set_data_t   set_data_i;
   adc_sample_t adc_a_i;
   adc_sample_t adc_b_i;
   logic        run_i;
   rx_sample_t  i_out_o;
   rx_sample_t  q_out_o;
   logic        compare;
   logic [31:0] rng_state;
   row_t        rows [NUM_ROWS];
   int          chk_errors;
   int          chk_checks;
   int          track_errors;

   rx_frontend uut (.*);

   rx_frontend_checker chk (
      .clk           (clk),
      .reset_i       (reset_i),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .adc_a_i       (adc_a_i),
      .adc_b_i       (adc_b_i),
      .compare_i     (compare),
      .i_out_i       (i_out_o),
      .q_out_i       (q_out_o),
      .error_count_o (chk_errors),
      .check_count_o (chk_checks)
   );

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state ^ (state << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic within_track_limit(input rx_sample_t value);
      return (value < TRACK_LIMIT) && (value > -TRACK_LIMIT);
   endfunction

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge clk);
   endtask

   task automatic stream_samples(input row_t row);
      for (int n = 0; n < row.count; n++)
      begin
         rng_state = xorshift32(rng_state);
         adc_a_i   = row.rnd ? rng_state[15:0] : row.const_a;
         adc_b_i   = row.rnd ? rng_state[31:16] : row.const_b;
         compare   = 1'b1;
         @(negedge clk);
      end
   endtask

   // the first outputs still belong to the previous row, so they are skipped
   task automatic wait_for_settling(input row_t row);
      int   cycles;
      logic settled;
      cycles  = 0;
      settled = 1'b0;
      adc_a_i = row.const_a;
      adc_b_i = row.const_b;
      while (!settled && cycles < row.count)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > PIPE_DEPTH)
            settled = within_track_limit(i_out_o) && within_track_limit(q_out_o);
      end
      if (!settled)
      begin
         $display("DC tracking did not bring both outputs under %0d within %0d cycles",
                  TRACK_LIMIT, row.count);
         track_errors++;
      end
   endtask

   task automatic run_row(input row_t row);
      run_i = row.run;
      write_setting(SR_SWAP, {31'd0, row.swap});
      write_setting(SR_MAG, {14'd0, row.mag});
      write_setting(SR_PHASE, {14'd0, row.phase});
      write_setting(SR_DC_I, row.dc_i);
      write_setting(SR_DC_Q, row.dc_q);
      set_stb_i = 1'b0;
      repeat (2) @(negedge clk);
      if (row.exact)
         stream_samples(row);
      else
         wait_for_settling(row);
      compare = 1'b0;
      repeat (PIPE_DEPTH) @(negedge clk);
   endtask

   initial
   begin
      reset_i      = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      adc_a_i      = '0;
      adc_b_i      = '0;
      run_i        = 1'b0;
      compare      = 1'b0;
      rng_state    = 32'd26;
      track_errors = 0;
      // swap, mag, phase, dc_i, dc_q, run, rnd, const a, const b, count, exact
      rows[0] = '{1'b0, 18'h00000, 18'h00000, 32'h8000_0000, 32'h8000_0000,
                  1'b0, 1'b1, 16'h0000, 16'h0000, 32'd64, 1'b1};
      rows[1] = '{1'b1, 18'h00000, 18'h00000, 32'h8000_0000, 32'h8000_0000,
                  1'b0, 1'b1, 16'h0000, 16'h0000, 32'd64, 1'b1};
      rows[2] = '{1'b0, 18'h00000, 18'h00000, 32'h8010_0000, 32'h80f0_0000,
                  1'b0, 1'b1, 16'h0000, 16'h0000, 32'd64, 1'b1};
      rows[3] = '{1'b0, 18'h00000, 18'h00000, 32'h807f_ffff, 32'h8080_0000,
                  1'b0, 1'b0, 16'h8000, 16'h7fff, 32'd16, 1'b1};
      rows[4] = '{1'b0, 18'h10000, 18'h3f000, 32'h8000_0000, 32'h8000_0000,
                  1'b0, 1'b1, 16'h0000, 16'h0000, 32'd128, 1'b1};
      rows[5] = '{1'b0, 18'h1ffff, 18'h20000, 32'h8000_0000, 32'h8000_0000,
                  1'b0, 1'b1, 16'h0000, 16'h0000, 32'd128, 1'b1};
      rows[6] = '{1'b0, 18'h00000, 18'h00000, 32'h0000_0000, 32'h0000_0000,
                  1'b1, 1'b0, 16'h1234, 16'h2345, 32'd200000, 1'b0};
      rows[7] = '{1'b1, 18'h00000, 18'h00000, 32'h0000_1000, 32'h00ff_f000,
                  1'b0, 1'b1, 16'h0000, 16'h0000, 32'd64, 1'b1};
      repeat (5) @(negedge clk);
      reset_i = 1'b0;
      repeat (PIPE_DEPTH) @(negedge clk);
      for (int r = 0; r < NUM_ROWS; r++)
         run_row(rows[r]);
      $display("summary: %0d output checks, %0d output errors, %0d tracking errors",
               chk_checks, chk_errors, track_errors);
      if (chk_errors == 0 && track_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire
